// File: Makefile
VERILATOR ?= verilator
TOP       ?= anc_tb
LINT_TOP  ?= anc_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard source/*.sv include/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/anc_params.svh
`ifndef ANC_PARAMS_SVH
`define ANC_PARAMS_SVH

// audio_clk cycles per half period of the microphone bit clock
`define ANC_BCLK_DIV 2

// Bit clocks in one I2S frame, half of them per slot
`define ANC_FRAME_BITS 64

// Bits captured from the start of the left slot
`define ANC_SAMPLE_BITS 16

// Entries in the delay buffer, a power of two
`define ANC_DELAY_DEPTH 64

`endif

// File: project.f
+incdir+include
source/anc_pkg.sv
source/i2s_mic_rx.sv
source/dc_offset_remover.sv
source/sample_delay_line.sv
source/pdm_modulator.sv
source/anc_control.sv
source/anc_top.sv
verification/anc_tb.sv

// File: source/anc_control.sv
`timescale 1ns/1ps
`default_nettype none

module anc_control
  import anc_pkg::*;
(
  input  wire logic        audio_clk,
  input  wire logic        arst_n,
  input  wire logic        offset_btn,
  output logic             capture,
  input  wire source_sel_t source_sel,
  input  wire delay_len_t  delay_len,
  input  wire sample_t     raw_sys,
  input  wire sample_t     proc_sys,
  input  wire sample_t     proc_ref,
  input  wire sample_t     delayed_sys,
  input  wire logic        delayed_valid,
  output sample_t          out_sample,
  output logic             out_valid
);

  logic [1:0] btn_sync;
  logic       btn_last;
  sample_t    anti_noise;
  sample_t    selected;

  assign capture = btn_sync[1] && !btn_last;

  // +32768 does not fit, so the most negative sample clips to the top
  assign anti_noise = (delayed_sys == SAMPLE_MIN) ? SAMPLE_MAX : -delayed_sys;

  // raw_sys is the receiver word, held there between strobes
  always_comb begin
    case (source_sel)
      SRC_RAW:        selected = raw_sys;
      SRC_PROCESSED:  selected = proc_sys;
      SRC_REFERENCE:  selected = proc_ref;
      SRC_ANTI_NOISE: selected = anti_noise;
      default:        selected = raw_sys;
    endcase
  end

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      btn_sync   <= '0;
      btn_last   <= 1'b0;
      out_sample <= '0;
      out_valid  <= 1'b0;
    end else begin
      btn_sync  <= {btn_sync[0], offset_btn};
      btn_last  <= btn_sync[1];
      out_valid <= delayed_valid;
      if (delayed_valid) begin
        out_sample <= selected;
      end
    end
  end

  // The delayed word must come from a read made with the current length
  a_len_settled: assert property (@(posedge audio_clk) disable iff (!arst_n)
    $changed(delay_len) |-> !delayed_valid);

endmodule

`default_nettype wire

// File: source/anc_pkg.sv
`default_nettype none
`include "anc_params.svh"

package anc_pkg;

  typedef logic signed [`ANC_SAMPLE_BITS-1:0] sample_t;

  // Saturation limits of a sample
  localparam sample_t SAMPLE_MAX = {1'b0, {(`ANC_SAMPLE_BITS-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(`ANC_SAMPLE_BITS-1){1'b0}}};

  typedef enum logic [1:0] {
    SRC_RAW        = 2'd0,
    SRC_PROCESSED  = 2'd1,
    SRC_REFERENCE  = 2'd2,
    SRC_ANTI_NOISE = 2'd3
  } source_sel_t;

  typedef logic [$clog2(`ANC_DELAY_DEPTH)-1:0] delay_len_t;

endpackage

`default_nettype wire

// File: source/anc_top.sv
`timescale 1ns/1ps
`default_nettype none

module anc_top
  import anc_pkg::*;
(
  input  wire logic        audio_clk,
  input  wire logic        arst_n,
  input  wire logic        mic_sys_data,
  input  wire logic        mic_ref_data,
  output logic             mic_bclk,
  output logic             mic_lrcl,
  input  wire logic        offset_btn,
  input  wire source_sel_t source_sel,
  input  wire delay_len_t  delay_len,
  output logic             spk_pdm,
  output sample_t          out_sample,
  output logic             out_valid
);

  sample_t raw_sys;
  sample_t raw_ref;
  logic    raw_sys_valid;
  logic    raw_ref_valid;
  sample_t proc_sys;
  sample_t proc_ref;
  logic    proc_sys_valid;
  sample_t delayed_sys;
  logic    delayed_valid;
  logic    capture;

  // System receiver owns the shared microphone clocks
  i2s_mic_rx mic_sys_rx_i (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .mic_data   (mic_sys_data),
    .bclk       (mic_bclk),
    .lrcl       (mic_lrcl),
    .word       (raw_sys),
    .word_valid (raw_sys_valid)
  );

  // Same reset and counters keep this one in lockstep
  i2s_mic_rx mic_ref_rx_i (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .mic_data   (mic_ref_data),
    .bclk       (),
    .lrcl       (),
    .word       (raw_ref),
    .word_valid (raw_ref_valid)
  );

  dc_offset_remover sys_offset_i (
    .audio_clk       (audio_clk),
    .arst_n          (arst_n),
    .raw             (raw_sys),
    .raw_valid       (raw_sys_valid),
    .capture         (capture),
    .processed       (proc_sys),
    .processed_valid (proc_sys_valid)
  );

  dc_offset_remover ref_offset_i (
    .audio_clk       (audio_clk),
    .arst_n          (arst_n),
    .raw             (raw_ref),
    .raw_valid       (raw_ref_valid),
    .capture         (capture),
    .processed       (proc_ref),
    .processed_valid ()
  );

  sample_delay_line delay_line_i (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .sample_in  (proc_sys),
    .in_valid   (proc_sys_valid),
    .delay_len  (delay_len),
    .sample_out (delayed_sys),
    .out_valid  (delayed_valid)
  );

  anc_control control_i (
    .audio_clk     (audio_clk),
    .arst_n        (arst_n),
    .offset_btn    (offset_btn),
    .capture       (capture),
    .source_sel    (source_sel),
    .delay_len     (delay_len),
    .raw_sys       (raw_sys),
    .proc_sys      (proc_sys),
    .proc_ref      (proc_ref),
    .delayed_sys   (delayed_sys),
    .delayed_valid (delayed_valid),
    .out_sample    (out_sample),
    .out_valid     (out_valid)
  );

  pdm_modulator pdm_i (
    .audio_clk (audio_clk),
    .arst_n    (arst_n),
    .level     (out_sample),
    .pdm       (spk_pdm)
  );

endmodule

`default_nettype wire

// File: source/dc_offset_remover.sv
`timescale 1ns/1ps
`default_nettype none

module dc_offset_remover
  import anc_pkg::*;
(
  input  wire logic    audio_clk,
  input  wire logic    arst_n,
  input  wire sample_t raw,
  input  wire logic    raw_valid,
  input  wire logic    capture,
  output sample_t      processed,
  output logic         processed_valid
);

  localparam int W = $bits(sample_t);

  sample_t      offset;
  sample_t      sub_offset;
  sample_t      sat;
  logic [W:0]   diff;
  logic         pending;

  // A pending capture already applies to the sample that loads it
  assign sub_offset = pending ? raw : offset;
  assign diff       = {raw[W-1], raw} - {sub_offset[W-1], sub_offset};

  always_comb begin
    if (diff[W] != diff[W-1]) begin
      sat = diff[W] ? SAMPLE_MIN : SAMPLE_MAX;
    end else begin
      sat = sample_t'(diff[W-1:0]);
    end
  end

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      pending         <= 1'b0;
      offset          <= '0;
      processed_valid <= 1'b0;
    end else begin
      processed_valid <= raw_valid;
      if (raw_valid) begin
        if (pending) begin
          offset <= raw;
        end
        // A press landing on a strobe waits for the next sample
        pending <= capture;
      end else if (capture) begin
        pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (raw_valid) begin
      processed <= sat;
    end
  end

endmodule

`default_nettype wire

// File: source/i2s_mic_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "anc_params.svh"

module i2s_mic_rx
  import anc_pkg::*;
(
  input  wire logic audio_clk,
  input  wire logic arst_n,
  input  wire logic mic_data,
  output logic      bclk,
  output logic      lrcl,
  output sample_t   word,
  output logic      word_valid
);

  localparam int DIV   = `ANC_BCLK_DIV;
  localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;
  localparam int FRAME = `ANC_FRAME_BITS;
  localparam int HALF  = FRAME / 2;
  localparam int CNT_W = $clog2(FRAME);
  localparam int NBITS = `ANC_SAMPLE_BITS;

  logic [DIV_W-1:0] div_cnt;
  logic [CNT_W-1:0] bit_cnt;
  logic [NBITS-1:0] shift;
  logic             div_wrap;
  logic             bclk_rise;
  logic             bclk_fall;
  logic             capture_bit;
  logic             last_bit;
  logic             word_done;

  assign div_wrap  = (div_cnt == DIV_W'(DIV - 1));
  assign bclk_rise = div_wrap && !bclk;
  assign bclk_fall = div_wrap && bclk;

  // MSB arrives one bit clock after lrcl falls
  assign capture_bit = bclk_rise && !lrcl &&
                       (bit_cnt >= CNT_W'(1)) && (bit_cnt <= CNT_W'(NBITS));
  assign last_bit    = bclk_rise && !lrcl && (bit_cnt == CNT_W'(NBITS));

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt    <= '0;
      bclk       <= 1'b0;
      bit_cnt    <= '0;
      lrcl       <= 1'b0;
      word_done  <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
      if (div_wrap) begin
        bclk <= !bclk;
      end
      // Counter and word clock move on the falling bit clock edge
      if (bclk_fall) begin
        bit_cnt <= (bit_cnt == CNT_W'(FRAME - 1)) ? '0 : bit_cnt + 1'b1;
        if ((bit_cnt == CNT_W'(HALF - 1)) || (bit_cnt == CNT_W'(FRAME - 1))) begin
          lrcl <= !lrcl;
        end
      end
      word_done  <= last_bit;
      word_valid <= word_done;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (capture_bit) begin
      shift <= {shift[NBITS-2:0], mic_data};
    end
    if (word_done) begin
      word <= sample_t'(shift);
    end
  end

  a_single_strobe: assert property (@(posedge audio_clk) disable iff (!arst_n)
    word_valid |=> !word_valid);

endmodule

`default_nettype wire

// File: source/pdm_modulator.sv
`timescale 1ns/1ps
`default_nettype none

module pdm_modulator
  import anc_pkg::*;
(
  input  wire logic    audio_clk,
  input  wire logic    arst_n,
  input  wire sample_t level,
  output logic         pdm
);

  localparam int W = $bits(sample_t);

  logic [W:0]   acc;
  logic [W-1:0] level_u;

  // Offset binary: -32768 maps to 0, 32767 to 65535
  assign level_u = {~level[W-1], level[W-2:0]};

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
    end else begin
      acc <= {1'b0, acc[W-1:0]} + {1'b0, level_u};
    end
  end

  // Carry out of the accumulator is the density bit
  assign pdm = acc[W];

endmodule

`default_nettype wire

// File: source/sample_delay_line.sv
`timescale 1ns/1ps
`default_nettype none
`include "anc_params.svh"

module sample_delay_line
  import anc_pkg::*;
(
  input  wire logic       audio_clk,
  input  wire logic       arst_n,
  input  wire sample_t    sample_in,
  input  wire logic       in_valid,
  input  wire delay_len_t delay_len,
  output sample_t         sample_out,
  output logic            out_valid
);

  localparam int DEPTH  = `ANC_DELAY_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int FILL_W = PTR_W + 1;

  sample_t           mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [FILL_W-1:0] fill;
  logic              filled;

  // Pointer arithmetic wraps because the depth is a power of two
  assign rd_ptr = wr_ptr - PTR_W'(delay_len);
  assign filled = (fill >= FILL_W'(delay_len));

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      fill      <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (fill != FILL_W'(DEPTH)) begin
          fill <= fill + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= sample_in;
      if (!filled) begin
        sample_out <= '0;
      end else if (delay_len == '0) begin
        sample_out <= sample_in;
      end else begin
        sample_out <= mem[rd_ptr];
      end
    end
  end

  a_len_stable: assert property (@(posedge audio_clk) disable iff (!arst_n)
    in_valid |-> $stable(delay_len));

endmodule

`default_nettype wire

// File: verification/anc_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "anc_params.svh"

module anc_tb
  import anc_pkg::*;
();

  localparam int MAX_ROWS     = 32;
  localparam int WORD_BITS    = `ANC_SAMPLE_BITS;
  localparam int HALF_BITS    = `ANC_FRAME_BITS / 2;
  localparam int FRAME_CYCLES = `ANC_FRAME_BITS * 2 * `ANC_BCLK_DIV;
  localparam int LATENCY      = 4;

  logic        audio_clk = 1'b0;
  logic        arst_n;
  logic        mic_sys_data = 1'b0;
  logic        mic_ref_data = 1'b0;
  logic        mic_bclk;
  logic        mic_lrcl;
  logic        offset_btn;
  source_sel_t source_sel;
  delay_len_t  delay_len;
  logic        spk_pdm;
  sample_t     out_sample;
  logic        out_valid;

  // Stimulus table
  string       row_name [MAX_ROWS];
  source_sel_t row_sel [MAX_ROWS];
  int          row_delay [MAX_ROWS];
  bit          row_press [MAX_ROWS];
  bit          row_pdm [MAX_ROWS];
  sample_t     row_sys [MAX_ROWS];
  sample_t     row_ref [MAX_ROWS];
  sample_t     row_expected [MAX_ROWS];
  int          n_rows = 0;

  int          cycles = 0;
  int          cycle_limit = 0;
  int          bit16_cycle = 0;
  int          value_errors = 0;
  int          pdm_errors = 0;
  int          other_errors = 0;

  // Microphone model state
  logic        prev_bclk;
  logic        prev_lrcl;
  int          slot_pos;
  int          frame;
  int          since_toggle;
  int          bclk_age;
  logic [15:0] lfsr;
  sample_t     sys_now;
  sample_t     ref_now;

  anc_top anc_top_i (
    .audio_clk    (audio_clk),
    .arst_n       (arst_n),
    .mic_sys_data (mic_sys_data),
    .mic_ref_data (mic_ref_data),
    .mic_bclk     (mic_bclk),
    .mic_lrcl     (mic_lrcl),
    .offset_btn   (offset_btn),
    .source_sel   (source_sel),
    .delay_len    (delay_len),
    .spk_pdm      (spk_pdm),
    .out_sample   (out_sample),
    .out_valid    (out_valid)
  );

  always #5 audio_clk = ~audio_clk;

  always @(posedge audio_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_advance(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  function automatic sample_t clip(input int value);
    if (value > 32767) begin
      return sample_t'(32767);
    end
    if (value < -32768) begin
      return sample_t'(-32768);
    end
    return sample_t'(value);
  endfunction

  // Data changes after each falling bit clock, ahead of the next rising edge
  always @(negedge audio_clk) begin
    if (!arst_n) begin
      prev_bclk    = 1'b0;
      prev_lrcl    = 1'b0;
      slot_pos     = 0;
      frame        = 0;
      since_toggle = 0;
      bclk_age     = 0;
      lfsr         = 16'd22;
      mic_sys_data = 1'b0;
      mic_ref_data = 1'b0;
    end else begin
      bclk_age = bclk_age + 1;
      if (mic_bclk != prev_bclk) begin
        if (bclk_age != `ANC_BCLK_DIV) begin
          $display("mic_bclk held a level for %0d cycles", bclk_age);
          other_errors++;
        end
        bclk_age = 0;
      end
      if (prev_bclk && !mic_bclk) begin
        since_toggle = since_toggle + 1;
        if (mic_lrcl != prev_lrcl) begin
          if (since_toggle != HALF_BITS) begin
            $display("mic_lrcl toggled after %0d bit clocks", since_toggle);
            other_errors++;
          end
          since_toggle = 0;
        end
        if (prev_lrcl && !mic_lrcl) begin
          slot_pos = 0;
          frame    = frame + 1;
        end else begin
          slot_pos = slot_pos + 1;
        end
        sys_now = (frame < n_rows) ? row_sys[frame] : '0;
        ref_now = (frame < n_rows) ? row_ref[frame] : '0;
        if (!mic_lrcl && slot_pos >= 1 && slot_pos <= WORD_BITS) begin
          mic_sys_data = sys_now[WORD_BITS - slot_pos];
          mic_ref_data = ref_now[WORD_BITS - slot_pos];
        end else begin
          mic_sys_data = lfsr[0];
          lfsr         = lfsr_advance(lfsr);
          mic_ref_data = lfsr[0];
          lfsr         = lfsr_advance(lfsr);
        end
      end else if (mic_lrcl != prev_lrcl) begin
        $display("mic_lrcl changed away from a falling mic_bclk edge");
        other_errors++;
      end
      if (!prev_bclk && mic_bclk && !mic_lrcl && slot_pos == WORD_BITS) begin
        bit16_cycle = cycles;
      end
      prev_bclk = mic_bclk;
      prev_lrcl = mic_lrcl;
    end
  end

  task automatic add_row(input string name, input source_sel_t sel, input int dly,
                         input bit press, input bit pdm, input int sys_word,
                         input int ref_word);
    row_name[n_rows]  = name;
    row_sel[n_rows]   = sel;
    row_delay[n_rows] = dly;
    row_press[n_rows] = press;
    row_pdm[n_rows]   = pdm;
    row_sys[n_rows]   = sample_t'(sys_word);
    row_ref[n_rows]   = sample_t'(ref_word);
    n_rows++;
  endtask

  // Reference model of offset capture, delay and source selection
  task automatic build_expected();
    int sys_off;
    int ref_off;
    int proc_ref;
    int delayed;
    int i;
    int hist [MAX_ROWS];
    sys_off = 0;
    ref_off = 0;
    for (i = 0; i < n_rows; i++) begin
      if (row_press[i]) begin
        sys_off = int'(row_sys[i]);
        ref_off = int'(row_ref[i]);
      end
      hist[i]  = int'(clip(int'(row_sys[i]) - sys_off));
      proc_ref = int'(clip(int'(row_ref[i]) - ref_off));
      delayed  = (i >= row_delay[i]) ? hist[i - row_delay[i]] : 0;
      case (row_sel[i])
        SRC_RAW:        row_expected[i] = row_sys[i];
        SRC_PROCESSED:  row_expected[i] = sample_t'(hist[i]);
        SRC_REFERENCE:  row_expected[i] = sample_t'(proc_ref);
        default:        row_expected[i] = clip(-delayed);
      endcase
    end
  endtask

  task automatic apply_row(input int i);
    source_sel = row_sel[i];
    delay_len  = delay_len_t'(row_delay[i]);
    offset_btn = row_press[i];
  endtask

  task automatic check_sample(input string name, input sample_t expected,
                              input sample_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual < expected - 1 || actual > expected + 1) begin
      $display("MISMATCH %s expected %0d (+/-1) actual %0d", name, expected, actual);
      pdm_errors++;
    end
  endtask

  task automatic wait_out_valid(output bit seen);
    int n;
    n = 0;
    while (!out_valid && n < FRAME_CYCLES + 64) begin
      @(negedge audio_clk);
      n++;
    end
    seen = out_valid;
  endtask

  task automatic count_pdm_ones(output int ones);
    ones = spk_pdm ? 1 : 0;
    repeat (FRAME_CYCLES - 1) begin
      @(negedge audio_clk);
      if (spk_pdm) begin
        ones++;
      end
    end
  endtask

  initial begin
    bit seen;
    int ones;
    int i;
    arst_n     = 1'b0;
    offset_btn = 1'b0;
    source_sel = SRC_RAW;
    delay_len  = '0;

    add_row("fill_d3_a", SRC_ANTI_NOISE, 3, 0, 0, 100, 0);
    add_row("fill_d3_b", SRC_ANTI_NOISE, 3, 0, 0, 200, 0);
    add_row("fill_d3_c", SRC_ANTI_NOISE, 3, 0, 0, 300, 0);
    add_row("anti_d3", SRC_ANTI_NOISE, 3, 0, 0, 400, 0);
    add_row("raw_pos", SRC_RAW, 3, 0, 0, 4660, 77);
    add_row("raw_min", SRC_RAW, 3, 0, 0, -32768, 0);
    add_row("raw_max", SRC_RAW, 3, 0, 0, 32767, 0);
    add_row("raw_neg", SRC_RAW, 3, 0, 0, -1234, 0);
    add_row("capture_a", SRC_PROCESSED, 3, 1, 0, 1000, -2000);
    add_row("proc_sys", SRC_PROCESSED, 3, 0, 0, 1500, 7);
    add_row("proc_ref", SRC_REFERENCE, 3, 0, 0, 1500, -2500);
    add_row("capture_b", SRC_PROCESSED, 3, 1, 0, 20000, -20000);
    add_row("sat_sys_low", SRC_PROCESSED, 3, 0, 0, -32768, 0);
    add_row("sat_ref_high", SRC_REFERENCE, 3, 0, 0, 5, 32767);
    add_row("ref_low", SRC_REFERENCE, 3, 0, 0, 5, -32768);
    add_row("anti_d10_a", SRC_ANTI_NOISE, 10, 0, 0, 0, 0);
    add_row("anti_d10_b", SRC_ANTI_NOISE, 10, 0, 0, 0, 0);
    add_row("capture_zero", SRC_PROCESSED, 10, 1, 0, 0, 0);
    add_row("anti_d0", SRC_ANTI_NOISE, 0, 0, 0, 300, 0);
    add_row("anti_d0_min", SRC_ANTI_NOISE, 0, 0, 0, -32768, 0);
    add_row("pdm_min", SRC_RAW, 0, 0, 1, -32768, 0);
    add_row("pdm_zero", SRC_RAW, 0, 0, 1, 0, 0);
    add_row("pdm_half", SRC_RAW, 0, 0, 1, 16384, 0);
    build_expected();
    cycle_limit = (n_rows + 4) * FRAME_CYCLES * 2;

    repeat (4) begin
      @(negedge audio_clk);
      if (mic_bclk !== 1'b0 || mic_lrcl !== 1'b0 || out_valid !== 1'b0 ||
          spk_pdm !== 1'b0) begin
        $display("clock, strobe or PDM output not low during reset");
        other_errors++;
      end
      check_sample("reset", '0, out_sample);
    end
    arst_n <= 1'b1;
    apply_row(0);

    for (i = 0; i < n_rows; i++) begin
      wait_out_valid(seen);
      if (!seen) begin
        $display("row %s: out_valid never arrived", row_name[i]);
        other_errors++;
      end else begin
        if (cycles - bit16_cycle != LATENCY) begin
          $display("row %s: out_valid came %0d cycles after bit 16",
                   row_name[i], cycles - bit16_cycle);
          other_errors++;
        end
        check_sample(row_name[i], row_expected[i], out_sample);
      end
      offset_btn = 1'b0;
      @(negedge audio_clk);
      if (i + 1 < n_rows) begin
        apply_row(i + 1);
      end
      // The count ends on the negedge where the next out_valid is high
      if (row_pdm[i]) begin
        count_pdm_ones(ones);
        check_count(row_name[i], ((int'(row_expected[i]) + 32768) * 256) / 65536, ones);
      end
    end

    $display("errors: %0d value, %0d pdm, %0d other", value_errors, pdm_errors,
             other_errors);
    if (value_errors + pdm_errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
